// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f mips_core.f --top-module mips_core_tb \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/mips_core_assert.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

// protocol rules on the core outputs, bound into mips_core
module mips_core_assert (
   input wire logic                   clk,
   input wire logic                   rst_b,
   input wire logic [3:0]             mem_write_en,
   input wire logic                   halted,
   input wire logic [`MIPS_ADDR_W-1:0] inst_addr
);

   // failed assertion attempts so far
   int err_cnt = 0;

   // full-word stores only
   a_we_legal: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en == 4'h0 || mem_write_en == 4'hF)
      else
      begin
         $error("mem_write_en is neither 0 nor F");
         err_cnt++;
      end

   // halt is sticky until reset
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else
      begin
         $error("halted dropped without reset");
         err_cnt++;
      end

   // fetch frozen once halted
   a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else
      begin
         $error("inst_addr moved while halted");
         err_cnt++;
      end

endmodule

`default_nettype wire

// File: bench/mips_core_check.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

// watches the data memory port and compares every store
module mips_core_check (
   input wire logic                    clk,
   input wire logic                    rst_b,
   input wire logic [`MIPS_ADDR_W-1:0] mem_addr,
   input wire logic [31:0]             mem_data_in,
   input wire logic [3:0]              mem_write_en,
   input wire logic                    halted
);

   int          pass_cnt = 0;
   int          fail_cnt = 0;
   string       cur_name;
   int          exp_cnt = 0;
   int          seen = 0;
   int          errs = 0;
   logic        active = 1'b0;
   logic [31:0] exp_addr [8];
   logic [31:0] exp_data [8];

   task automatic begin_test(input string name, input int cnt,
                             input logic [31:0] addrs [8], input logic [31:0] datas [8]);
      cur_name = name;
      exp_cnt  = cnt;
      seen     = 0;
      errs     = 0;
      exp_addr = addrs;
      exp_data = datas;
      active   = 1'b1;
   endtask

   // one line per test
   task automatic end_test();
      if (seen != exp_cnt)
      begin
         $display("%s: expected %0d stores but saw %0d", cur_name, exp_cnt, seen);
         errs++;
      end
      if (errs == 0)
      begin
         $display("pass %s", cur_name);
         pass_cnt++;
      end
      else
      begin
         $display("fail %s with %0d errors", cur_name, errs);
         fail_cnt++;
      end
      active = 1'b0;
   endtask

   // outputs are sampled before the edge updates the core
   always @(posedge clk)
   begin
      if (active && rst_b && mem_write_en == 4'hF)
      begin
         if (halted)
         begin
            $display("%s: store issued after halt", cur_name);
            errs++;
         end
         else if (seen >= exp_cnt)
         begin
            // e.g. a store past a taken branch's delay slot
            $display("%s: unexpected store to word address %h", cur_name, mem_addr);
            errs++;
         end
         else
         begin
            if (mem_addr != exp_addr[seen][31:2])
            begin
               $display("error mem_addr exp=%h got=%h", exp_addr[seen][31:2], mem_addr);
               errs++;
            end
            if (mem_data_in != exp_data[seen])
            begin
               $display("error mem_data_in exp=%h got=%h", exp_data[seen], mem_data_in);
               errs++;
            end
         end
         seen++;
      end
   end

endmodule

`default_nettype wire

// File: bench/mips_core_tb.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

module mips_core_tb;

   localparam int NT = 6;
   localparam logic [31:0] SC = 32'h0000_000c;
   // primary opcodes
   localparam int ADDIU = 'h09;
   localparam int ANDI = 'h0c;
   localparam int ORI = 'h0d;
   localparam int LUI = 'h0f;
   localparam int LW = 'h23;
   localparam int SW = 'h2b;
   localparam int BEQ = 'h04;
   localparam int BNE = 'h05;
   localparam int JAL = 'h03;
   // funct codes
   localparam int F_SLL = 'h00;
   localparam int F_JR = 'h08;
   localparam int F_ADDU = 'h21;
   localparam int F_SUBU = 'h23;
   localparam int F_AND = 'h24;
   localparam int F_OR = 'h25;
   localparam int F_XOR = 'h26;
   localparam int F_NOR = 'h27;
   localparam int F_SLT = 'h2a;

   logic                    clk = 1'b0;
   logic                    rst_b = 1'b0;
   logic [31:0]             inst;
   logic [31:0]             mem_data_out;
   logic [`MIPS_ADDR_W-1:0] inst_addr;
   logic [`MIPS_ADDR_W-1:0] mem_addr;
   logic [31:0]             mem_data_in;
   logic [3:0]              mem_write_en;
   logic                    halted;

   // set when a test never reaches halted
   logic hung = 1'b0;

   logic [31:0] imem [64];
   logic [31:0] dmem [64];

   // test table
   string       names [NT];
   logic [31:0] progs [NT][12];
   int          nst [NT];
   logic [31:0] st_addr [NT][8];
   logic [31:0] st_data [NT][8];

   initial
   begin
      forever #4 clk = ~clk;
   end

   mips_core uut (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_data_out(mem_data_out),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
      .mem_write_en(mem_write_en), .halted(halted)
   );

   mips_core_check chk (
      .clk(clk), .rst_b(rst_b), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
      .mem_write_en(mem_write_en), .halted(halted)
   );

   bind mips_core mips_core_assert u_assert (
      .clk(clk), .rst_b(rst_b), .mem_write_en(mem_write_en),
      .halted(halted), .inst_addr(inst_addr)
   );

   // both memories read combinationally, 64 words wrap
   assign inst         = imem[inst_addr[5:0]];
   assign mem_data_out = dmem[mem_addr[5:0]];

   always @(posedge clk)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < 64; i++)
            dmem[i] <= '0;
      end
      else if (mem_write_en == 4'hF)
         dmem[mem_addr[5:0]] <= mem_data_in;
   end

   function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                         input int sh, input int fn);
      return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
   endfunction

   function automatic logic [31:0] itype(input int op, input int rs, input int rt,
                                         input int imm);
      return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] jtype(input int op, input int tgt);
      return {op[5:0], tgt[25:0]};
   endfunction

   task automatic build_table();
      names = '{"arith_a", "arith_b", "immediates", "load_store", "branches", "jumps"};
      nst   = '{4, 4, 4, 2, 5, 2};
      // $1 = -6, $2 = 19
      progs[0] = '{itype(ADDIU, 0, 1, 'hfffa), itype(ADDIU, 0, 2, 'h13),
         rtype(1, 2, 3, 0, F_ADDU), itype(SW, 0, 3, 'h0), rtype(1, 2, 4, 0, F_SUBU),
         itype(SW, 0, 4, 'h4), rtype(1, 2, 5, 0, F_AND), itype(SW, 0, 5, 'h8),
         rtype(1, 2, 6, 0, F_OR), itype(SW, 0, 6, 'hc), SC, SC};
      st_addr[0] = '{'h0, 'h4, 'h8, 'hc, 0, 0, 0, 0};
      st_data[0] = '{'hd, 'hffffffe7, 'h12, 'hfffffffb, 0, 0, 0, 0};
      // slt with a negative rs, sll by 4
      progs[1] = '{itype(ADDIU, 0, 1, 'hfffa), itype(ADDIU, 0, 2, 'h13),
         rtype(1, 2, 3, 0, F_XOR), itype(SW, 0, 3, 'h10), rtype(1, 2, 4, 0, F_NOR),
         itype(SW, 0, 4, 'h14), rtype(1, 2, 5, 0, F_SLT), itype(SW, 0, 5, 'h18),
         rtype(0, 2, 6, 4, F_SLL), itype(SW, 0, 6, 'h1c), SC, SC};
      st_addr[1] = '{'h10, 'h14, 'h18, 'h1c, 0, 0, 0, 0};
      st_data[1] = '{'hffffffe9, 'h4, 'h1, 'h130, 0, 0, 0, 0};
      // addiu sign-extends, andi/ori zero-extend, lui+ori builds a word
      progs[2] = '{itype(ADDIU, 0, 1, 'h8001), itype(ANDI, 1, 2, 'hf00f),
         itype(ORI, 0, 3, 'h8000), itype(LUI, 0, 4, 'h1234), itype(ORI, 4, 4, 'h5678),
         itype(SW, 0, 1, 'h20), itype(SW, 0, 2, 'h24), itype(SW, 0, 3, 'h28),
         itype(SW, 0, 4, 'h2c), SC, SC, SC};
      st_addr[2] = '{'h20, 'h24, 'h28, 'h2c, 0, 0, 0, 0};
      st_data[2] = '{'hffff8001, 'h8001, 'h8000, 'h12345678, 0, 0, 0, 0};
      // the store after syscall must never show up
      progs[3] = '{itype(ADDIU, 0, 1, 'h55), itype(SW, 0, 1, 'h40), itype(LW, 0, 2, 'h40),
         itype(ADDIU, 2, 2, 1), itype(SW, 0, 2, 'h44), SC, itype(SW, 0, 2, 'h48),
         SC, SC, SC, SC, SC};
      st_addr[3] = '{'h40, 'h44, 0, 0, 0, 0, 0, 0};
      st_data[3] = '{'h55, 'h56, 0, 0, 0, 0, 0, 0};
      // beq not taken, beq taken, bne taken, bne not taken
      progs[4] = '{itype(ADDIU, 0, 1, 5), itype(BEQ, 1, 0, 2), itype(SW, 0, 1, 'h60),
         itype(SW, 0, 1, 'h64), itype(BEQ, 1, 1, 2), itype(SW, 0, 1, 'h68),
         itype(SW, 0, 1, 'h6c), itype(BNE, 1, 0, 2), itype(SW, 0, 1, 'h70),
         itype(SW, 0, 1, 'h74), itype(BNE, 1, 1, 0), itype(SW, 0, 1, 'h78)};
      st_addr[4] = '{'h60, 'h64, 'h68, 'h70, 'h78, 0, 0, 0};
      st_data[4] = '{5, 5, 5, 5, 5, 0, 0, 0};
      // jal to word 4, link is 0x00400008, jr returns to word 2
      progs[5] = '{jtype(JAL, 'h100004), itype(ADDIU, 0, 2, 7), itype(SW, 0, 2, 'h84),
         SC, itype(SW, 0, 31, 'h80), rtype(31, 0, 0, 0, F_JR), itype(ADDIU, 0, 3, 1),
         SC, SC, SC, SC, SC};
      st_addr[5] = '{'h80, 'h84, 0, 0, 0, 0, 0, 0};
      st_data[5] = '{'h00400008, 7, 0, 0, 0, 0, 0, 0};
   endtask

   task automatic run_test(input int t);
      int cyc;
      @(posedge clk);
      rst_b <= 1'b0;
      for (int i = 0; i < 64; i++)
         imem[i] <= (i < 12) ? progs[t][i] : SC;
      repeat (10) @(posedge clk);
      chk.begin_test(names[t], nst[t], st_addr[t], st_data[t]);
      rst_b <= 1'b1;
      cyc = 0;
      // halted is sampled mid-cycle
      @(negedge clk);
      while (!halted && cyc < 200)
      begin
         @(negedge clk);
         cyc++;
      end
      if (!halted)
      begin
         $display("%s: core did not halt within 200 cycles", names[t]);
         hung = 1'b1;
      end
      else
      begin
         // a few cycles to catch stray writes after halt
         repeat (4) @(negedge clk);
         chk.end_test();
      end
   endtask

   initial
   begin
      for (int i = 0; i < 64; i++)
         imem[i] = SC;
      build_table();
      for (int t = 0; t < NT && !hung; t++)
         run_test(t);
      $display("tests=%0d passed=%0d failed=%0d assert_errs=%0d", NT,
               chk.pass_cnt, chk.fail_cnt, uut.u_assert.err_cnt);
      if (!hung && chk.fail_cnt == 0 && uut.u_assert.err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/mips_core.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

module mips_core import mips_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst_b,
   input  wire word_t                   inst,
   input  wire word_t                   mem_data_out,
   output logic [`MIPS_ADDR_W-1:0]      inst_addr,
   output logic [`MIPS_ADDR_W-1:0]      mem_addr,
   output word_t                        mem_data_in,
   output logic [3:0]                   mem_write_en,
   output logic                         halted
);

   // instruction fields
   opcode_t     opcode;
   funct_t      funct;
   reg_idx_t    rs;
   reg_idx_t    rt;
   reg_idx_t    rd;
   logic [4:0]  shamt;
   logic [15:0] imm16;
   logic [25:0] target;

   word_t    pc;
   word_t    rs_data;
   word_t    rt_data;
   word_t    alu_out;
   logic     alu_zero;
   reg_idx_t wr_idx;
   word_t    wr_data;

   mips_ctrl_if ctrl ();

   assign opcode = opcode_t'(inst[31:26]);
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign funct  = funct_t'(inst[5:0]);
   assign imm16  = inst[15:0];
   assign target = inst[25:0];

   mips_decode u_decode (
      .clk(clk), .rst_b(rst_b), .opcode(opcode), .funct(funct),
      .ctrl(ctrl.decode), .halted(halted)
   );

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .halted(halted), .ctrl(ctrl.fetch),
      .rs_data(rs_data), .alu_zero(alu_zero), .imm16(imm16),
      .target(target), .pc(pc)
   );

   // jal always links through $ra
   assign wr_idx = (ctrl.wb_sel == WB_LINK) ? `MIPS_LINK_REG :
                   ctrl.reg_dst_rd          ? rd : rt;

   // link value skips the delay slot
   always_comb
   begin
      case (ctrl.wb_sel)
         WB_MEM:  wr_data = mem_data_out;
         WB_LINK: wr_data = pc + 32'd8;
         default: wr_data = alu_out;
      endcase
   end

   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b), .rs_idx(rs), .rt_idx(rt), .rd_idx(wr_idx),
      .wr_data(wr_data), .we(ctrl.reg_we), .rs_data(rs_data), .rt_data(rt_data)
   );

   mips_execute u_execute (
      .ctrl(ctrl.execute), .rs_data(rs_data), .rt_data(rt_data),
      .imm16(imm16), .shamt(shamt), .alu_out(alu_out), .alu_zero(alu_zero)
   );

   // word-addressed memory ports, full-word stores only
   assign inst_addr    = pc[`MIPS_DATA_W-1:2];
   assign mem_addr     = alu_out[`MIPS_DATA_W-1:2];
   assign mem_data_in  = rt_data;
   assign mem_write_en = {4{ctrl.mem_we}};

endmodule

`default_nettype wire

// File: logic/mips_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

// decoded control for the instruction in flight
interface mips_ctrl_if import mips_pkg::*; ();

   alu_op_t alu_op;
   // second alu operand is the extended immediate, not rt
   logic    alu_src_imm;
   // sign- rather than zero-extend imm16
   logic    imm_sign;
   // destination is rd (r-type), else rt
   logic    reg_dst_rd;
   logic    reg_we;
   wb_sel_t wb_sel;
   pc_sel_t pc_sel;
   // branch on not-equal (bne) instead of equal
   logic    br_ne;
   logic    mem_we;

   modport decode (
      output alu_op, alu_src_imm, imm_sign, reg_dst_rd, reg_we,
      output wb_sel, pc_sel, br_ne, mem_we
   );

   modport fetch (input pc_sel, br_ne);

   modport execute (input alu_op, alu_src_imm, imm_sign);

endinterface

`default_nettype wire

// File: logic/mips_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decode import mips_pkg::*; (
   input  wire logic    clk,
   input  wire logic    rst_b,
   input  wire opcode_t opcode,
   input  wire funct_t  funct,
   mips_ctrl_if.decode  ctrl,
   output logic         halted
);

   // current instruction is a syscall
   logic sys_hit;

   always_comb
   begin
      // defaults describe a no-op that falls through to next-pc + 4
      ctrl.alu_op      = ALU_ADD;
      ctrl.alu_src_imm = 1'b0;
      ctrl.imm_sign    = 1'b0;
      ctrl.reg_dst_rd  = 1'b0;
      ctrl.reg_we      = 1'b0;
      ctrl.wb_sel      = WB_ALU;
      ctrl.pc_sel      = PC_SEQ;
      ctrl.br_ne       = 1'b0;
      ctrl.mem_we      = 1'b0;
      sys_hit          = 1'b0;
      case (opcode)
         OP_SPECIAL:
         begin
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_we     = 1'b1;
            case (funct)
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_JR:
               begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = PC_REG;
               end
               FN_SYSCALL:
               begin
                  ctrl.reg_we = 1'b0;
                  sys_hit     = 1'b1;
               end
               // unknown funct does nothing
               default: ctrl.reg_we = 1'b0;
            endcase
         end
         OP_J:
            ctrl.pc_sel = PC_JUMP;
         OP_JAL:
         begin
            // link register is picked by the top level from wb_sel
            ctrl.pc_sel = PC_JUMP;
            ctrl.reg_we = 1'b1;
            ctrl.wb_sel = WB_LINK;
         end
         OP_BEQ, OP_BNE:
         begin
            // rs - rt feeds alu_zero
            ctrl.alu_op = ALU_SUB;
            ctrl.pc_sel = PC_BRANCH;
            ctrl.br_ne  = (opcode == OP_BNE);
         end
         OP_ADDIU, OP_LW, OP_SW:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.reg_we      = (opcode != OP_SW);
            ctrl.mem_we      = (opcode == OP_SW);
            ctrl.wb_sel      = (opcode == OP_LW) ? WB_MEM : WB_ALU;
         end
         OP_ANDI, OP_ORI, OP_LUI:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
            ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND :
                               (opcode == OP_ORI)  ? ALU_OR  : ALU_LUI;
         end
         default:
            ctrl.reg_we = 1'b0;
      endcase
      // no architectural side effects once halted
      if (halted)
      begin
         ctrl.reg_we = 1'b0;
         ctrl.mem_we = 1'b0;
      end
   end

   // sticky until reset
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         halted <= 1'b0;
      else if (sys_hit)
         halted <= 1'b1;
   end

endmodule

`default_nettype wire

// File: logic/mips_execute.sv
`timescale 1ns/1ns
`default_nettype none

module mips_execute import mips_pkg::*; (
   mips_ctrl_if.execute     ctrl,
   input  wire word_t       rs_data,
   input  wire word_t       rt_data,
   input  wire logic [15:0] imm16,
   input  wire logic [4:0]  shamt,
   output word_t            alu_out,
   output logic             alu_zero
);

   word_t imm_ext;
   word_t op_b;

   // addiu, lw and sw sign-extend; andi and ori zero-extend
   assign imm_ext = ctrl.imm_sign ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

   assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

   always_comb
   begin
      case (ctrl.alu_op)
         ALU_ADD:
            alu_out = rs_data + op_b;
         ALU_SUB:
            alu_out = rs_data - op_b;
         ALU_AND:
            alu_out = rs_data & op_b;
         ALU_OR:
            alu_out = rs_data | op_b;
         ALU_XOR:
            alu_out = rs_data ^ op_b;
         ALU_NOR:
            alu_out = ~(rs_data | op_b);
         // signed compare, result is 0 or 1
         ALU_SLT:
            alu_out = ($signed(rs_data) < $signed(op_b)) ? 32'd1 : 32'd0;
         // shift amount comes from the instruction, not rs
         ALU_SLL:
            alu_out = rt_data << shamt;
         ALU_LUI:
            alu_out = {imm16, 16'h0000};
         default:
            alu_out = '0;
      endcase
   end

   // only meaningful for beq/bne, where the op is a subtract
   assign alu_zero = (alu_out == '0);

endmodule

`default_nettype wire

// File: logic/mips_fetch.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

module mips_fetch import mips_pkg::*; (
   input  wire logic        clk,
   input  wire logic        rst_b,
   input  wire logic        halted,
   mips_ctrl_if.fetch       ctrl,
   input  wire word_t       rs_data,
   input  wire logic        alu_zero,
   input  wire logic [15:0] imm16,
   input  wire logic [25:0] target,
   output word_t            pc
);

   // address of the delay-slot instruction
   word_t next_pc;
   word_t seq_pc;
   word_t br_target;
   word_t j_target;
   word_t new_pc;
   logic  br_taken;

   assign seq_pc = next_pc + 32'd4;

   // offset is in words, relative to the delay slot
   assign br_target = pc + 32'd4 + {{14{imm16[15]}}, imm16, 2'b00};

   // region bits come from the jump's own pc
   assign j_target = {pc[31:28], target, 2'b00};

   // alu_zero means rs == rt
   assign br_taken = alu_zero ^ ctrl.br_ne;

   always_comb
   begin
      case (ctrl.pc_sel)
         PC_BRANCH: new_pc = br_taken ? br_target : seq_pc;
         PC_REG:    new_pc = rs_data;
         PC_JUMP:   new_pc = j_target;
         default:   new_pc = seq_pc;
      endcase
   end

   // pc takes next_pc so a redirect lands one instruction late
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc      <= `MIPS_TEXT_START;
         next_pc <= `MIPS_TEXT_START + 32'd4;
      end
      else if (!halted)
      begin
         pc      <= next_pc;
         next_pc <= new_pc;
      end
   end

endmodule

`default_nettype wire

// File: logic/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word width
`define MIPS_DATA_W 32

// word address width seen by the instruction and data memories
`define MIPS_ADDR_W 30

// register file geometry
`define MIPS_REG_AW 5
`define MIPS_REG_CNT 32

// jal writes its return address here ($ra)
`define MIPS_LINK_REG 5'd31

// first instruction fetched after reset
// next-pc starts one word later so the first fetch has no delay slot
`define MIPS_TEXT_START 32'h0040_0000

`endif

// File: logic/mips_pkg.sv
`include "mips_params.svh"
`default_nettype none

package mips_pkg;

   typedef logic [`MIPS_DATA_W-1:0] word_t;
   typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

   // primary opcodes, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_t;

   // funct codes under OP_SPECIAL, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_t;

   // alu_lui passes imm16 into the upper half
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLT, ALU_SLL, ALU_LUI
   } alu_op_t;

   // next-pc source
   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP} pc_sel_t;

   // register writeback source
   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

endpackage

`default_nettype wire

// File: logic/mips_regfile.sv
`timescale 1ns/1ns
`include "mips_params.svh"
`default_nettype none

module mips_regfile import mips_pkg::*; (
   input  wire logic     clk,
   input  wire logic     rst_b,
   input  wire reg_idx_t rs_idx,
   input  wire reg_idx_t rt_idx,
   input  wire reg_idx_t rd_idx,
   input  wire word_t    wr_data,
   input  wire logic     we,
   output word_t         rs_data,
   output word_t         rt_data
);

   word_t regs [`MIPS_REG_CNT];

   // $zero reads as zero whatever the array holds
   assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
   assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < `MIPS_REG_CNT; i++)
            regs[i] <= '0;
      end
      else if (we && rd_idx != '0)
         regs[rd_idx] <= wr_data;
   end

endmodule

`default_nettype wire

// File: mips_core.f
+incdir+logic
logic/mips_pkg.sv
logic/mips_ctrl_if.sv
logic/mips_decode.sv
logic/mips_fetch.sv
logic/mips_regfile.sv
logic/mips_execute.sv
logic/mips_core.sv
bench/mips_core_assert.sv
bench/mips_core_check.sv
bench/mips_core_tb.sv
